// ==== shuffle_pkg.sv ====
package shuffle_pkg;

  typedef logic [31:0] instr_t;    // uncompressed RV32I instruction word
  typedef logic [31:0] addr_t;     // program counter of an instruction
  typedef logic [4:0]  log_reg_t;  // architectural register index x0..x31

  localparam int unsigned NUM_LOG_REGS = 32;

  // major opcodes, bits [6:0] of the instruction
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // ecall, ebreak, xret, wfi and csr
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register alu ops

  // what the shuffling logic needs to know about one instruction
  typedef struct packed {
    logic has_rd;    // writes a destination register
    logic has_rs1;   // reads rs1
    logic has_rs2;   // reads rs2
    logic is_fence;  // may redirect the pc, so acceptance must stop behind it
    logic is_mem;    // load or store
    logic is_env;    // any SYSTEM opcode, fully ordered
  } instr_class_t;

endpackage

// ==== shuffle_if.sv ====
`timescale 1ns/100ps

interface shuffle_if #(
  parameter int unsigned DEPTH = 4
);

  logic                     ins_en;   // an upstream instruction is written this cycle
  logic [$clog2(DEPTH)-1:0] ins_idx;  // slot that receives it
  logic                     rem_en;   // the slot at rem_idx goes to ID/EX this cycle
  logic [$clog2(DEPTH)-1:0] rem_idx;  // slot shown on the downstream outputs
  logic [DEPTH-1:0]         valid;    // occupied slots, registered

  // the top level owns the handshake and the slot valid bits
  modport ctrl (output ins_en, rem_en, valid, input ins_idx, rem_idx);

  // issue_select chooses both slot indices
  modport sel (output ins_idx, rem_idx, input ins_en, rem_en, valid);

  // rename and dependency bookkeeping only follow the events
  modport track (input ins_en, ins_idx, rem_en, rem_idx, valid);

endinterface

// ==== instr_classify.sv ====
`timescale 1ns/100ps

module instr_classify import shuffle_pkg::*; (
  input  instr_t       in_instr_i,
  output instr_class_t cls_o,
  output log_reg_t     rd_o,
  output log_reg_t     rs1_o,
  output log_reg_t     rs2_o
);

  logic [6:0] opc;
  logic [2:0] funct3;
  logic       is_system;
  logic       is_priv;     // ecall, ebreak, xret and wfi share funct3 = 0
  logic       is_csr_imm;  // csrrwi, csrrsi, csrrci carry a zimm in the rs1 field

  assign opc        = in_instr_i[6:0];
  assign funct3     = in_instr_i[14:12];
  assign is_system  = (opc == OPC_SYSTEM);
  assign is_priv    = is_system && (funct3 == 3'b000);
  assign is_csr_imm = is_system && (funct3 inside {3'b101, 3'b110, 3'b111});

  // register fields sit at the same place for every format
  assign rd_o  = in_instr_i[11:7];
  assign rs1_o = in_instr_i[19:15];
  assign rs2_o = in_instr_i[24:20];

  // B-type, S-type, fence and the privileged group have no destination
  assign cls_o.has_rd = !(opc == OPC_BRANCH || opc == OPC_STORE || opc == OPC_FENCE || is_priv);

  assign cls_o.has_rs1 = !(opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_JAL
                           || opc == OPC_FENCE || is_priv || is_csr_imm);

  assign cls_o.has_rs2 = (opc == OPC_BRANCH) || (opc == OPC_STORE) || (opc == OPC_OP);

  // bits [22:21] tell ecall/ebreak (00) and sret/mret (01) apart from wfi
  assign cls_o.is_fence = (opc == OPC_JAL) || (opc == OPC_JALR) || (opc == OPC_BRANCH)
                          || (opc == OPC_FENCE)
                          || (is_priv && (in_instr_i[22:21] == 2'b00
                                          || in_instr_i[22:21] == 2'b01));

  assign cls_o.is_mem = (opc == OPC_LOAD) || (opc == OPC_STORE);
  assign cls_o.is_env = is_system;  // csr accesses are ordered like ecall

endmodule

// ==== rename_table.sv ====
`timescale 1ns/100ps

module rename_table import shuffle_pkg::*; #(
  parameter int unsigned  DEPTH         = 4,
  parameter int unsigned  NUM_PHYS_REGS = 64,
  localparam int unsigned PHYS_W        = $clog2(NUM_PHYS_REGS)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  shuffle_if.track          ev,
  input  instr_class_t      cls_i,
  input  log_reg_t          rd_i,
  input  log_reg_t          rs1_i,
  input  log_reg_t          rs2_i,
  output logic [PHYS_W-1:0] prd_o,
  output logic [PHYS_W-1:0] prs1_o,
  output logic [PHYS_W-1:0] prs2_o
);

  typedef logic [PHYS_W-1:0]        phys_idx_t;
  typedef logic [NUM_PHYS_REGS-1:0] phys_vec_t;

  phys_idx_t map_q [NUM_LOG_REGS];  // current physical home of each logical register
  phys_vec_t reserved_q;            // one bit per physical register named by map_q
  phys_vec_t usage_q [DEPTH];       // registers touched by the instruction in each slot
  phys_vec_t in_use;
  phys_idx_t free_idx;
  logic      alloc;

  // a register is busy if it is mapped or still referenced by a buffered entry,
  // since a released mapping may be read by an older instruction not yet issued
  always_comb begin
    in_use = reserved_q;
    for (int i = 0; i < DEPTH; i++) begin
      if (ev.valid[i]) begin
        in_use |= usage_q[i];
      end
    end
    free_idx = '0;
    for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
      if (!in_use[i]) begin
        free_idx = PHYS_W'(i);  // descending scan leaves the lowest free index
      end
    end
  end

  assign alloc  = cls_i.has_rd && (rd_i != '0);        // x0 writes are discarded
  assign prd_o  = alloc ? free_idx : '0;
  assign prs1_o = cls_i.has_rs1 ? map_q[rs1_i] : '0;   // sources see the map before the update
  assign prs2_o = cls_i.has_rs2 ? map_q[rs2_i] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_LOG_REGS; i++) begin
        map_q[i] <= PHYS_W'(i);  // identity mapping out of reset
      end
      for (int i = 0; i < NUM_PHYS_REGS; i++) begin
        reserved_q[i] <= (i < NUM_LOG_REGS);
      end
      for (int i = 0; i < DEPTH; i++) begin
        usage_q[i] <= '0;
      end
    end else begin
      if (ev.rem_en) begin
        usage_q[ev.rem_idx] <= '0;
      end
      // an insert into the slot being issued wins, it is written last
      if (ev.ins_en) begin
        usage_q[ev.ins_idx] <= (phys_vec_t'(1) << prd_o) | (phys_vec_t'(1) << prs1_o)
                               | (phys_vec_t'(1) << prs2_o);
        if (alloc) begin
          reserved_q[map_q[rd_i]] <= 1'b0;  // old home is free once no entry uses it
          reserved_q[free_idx]    <= 1'b1;
          map_q[rd_i]             <= free_idx;
        end
      end
    end
  end

endmodule

// ==== dep_matrix.sv ====
`timescale 1ns/100ps

module dep_matrix import shuffle_pkg::*; #(
  parameter int unsigned  DEPTH         = 4,
  parameter int unsigned  NUM_PHYS_REGS = 64,
  localparam int unsigned PHYS_W        = $clog2(NUM_PHYS_REGS)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  shuffle_if.track          ev,
  input  instr_class_t      cls_i,
  input  logic [PHYS_W-1:0] prd_i,
  input  logic [PHYS_W-1:0] prs1_i,
  input  logic [PHYS_W-1:0] prs2_i,
  output logic [DEPTH-1:0]  ready_o
);

  typedef logic [PHYS_W-1:0] phys_idx_t;
  typedef logic [DEPTH-1:0]  slot_vec_t;

  slot_vec_t dep_q [DEPTH];  // row i holds the older slots that slot i waits for
  slot_vec_t mem_q;          // slot holds a load or store
  slot_vec_t env_q;          // slot holds a SYSTEM instruction
  phys_idx_t rd_q [DEPTH];   // renamed destination of each slot
  slot_vec_t new_row;

  always_comb begin
    new_row = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (ev.valid[i]) begin
        // read after write on a physical register, p0 never carries a result
        if ((rd_q[i] != '0) && (rd_q[i] == prs1_i || rd_q[i] == prs2_i)) begin
          new_row[i] = 1'b1;
        end
        if (mem_q[i] && cls_i.is_mem) begin
          new_row[i] = 1'b1;  // memory ops keep program order
        end
        if (cls_i.is_env || env_q[i]) begin
          new_row[i] = 1'b1;  // nothing passes an env/csr instruction either way
        end
      end
    end
    // the issuing slot may still look valid when it is reused in the same cycle
    new_row[ev.ins_idx] = 1'b0;
  end

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready_o[i] = ev.valid[i] && (dep_q[i] == '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        dep_q[i] <= '0;
      end
      mem_q <= '0;
      env_q <= '0;
    end else begin
      if (ev.rem_en) begin
        for (int i = 0; i < DEPTH; i++) begin
          dep_q[i][ev.rem_idx] <= 1'b0;  // release everyone waiting on the issued slot
        end
      end
      if (ev.ins_en) begin
        dep_q[ev.ins_idx] <= new_row;
        mem_q[ev.ins_idx] <= cls_i.is_mem;
        env_q[ev.ins_idx] <= cls_i.is_env;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ev.ins_en) begin
      rd_q[ev.ins_idx] <= prd_i;
    end
  end

endmodule

// ==== issue_select.sv ====
`timescale 1ns/100ps

module issue_select #(
  parameter int unsigned  DEPTH    = 4,
  parameter logic [15:0]  RNG_SEED = 16'hACE1,
  localparam int unsigned SLOT_W   = $clog2(DEPTH)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  shuffle_if.sel           ev,
  input  logic [DEPTH-1:0] ready_i,
  output logic             pick_ok_o
);

  typedef logic [SLOT_W-1:0]                      slot_idx_t;
  typedef logic [DEPTH-1:0][DEPTH-1:0][SLOT_W-1:0] dist_t;

  // entry [k][c] is the k-th closest slot to c, visiting c, c+1, c-1, c+2 ...
  function automatic dist_t build_dist();
    dist_t tbl;
    int    off;
    for (int c = 0; c < DEPTH; c++) begin
      for (int k = 0; k < DEPTH; k++) begin
        off = (k + 1) / 2;
        if (k % 2 == 1) begin
          tbl[k][c] = SLOT_W'((c + off) % DEPTH);
        end else begin
          tbl[k][c] = SLOT_W'((c + DEPTH - off) % DEPTH);
        end
      end
    end
    return tbl;
  endfunction

  localparam dist_t DIST = build_dist();

  logic [15:0]      lfsr_q;
  slot_idx_t        rnd;
  logic [DEPTH-1:0] cand;       // readiness in the distance order of the chosen column
  slot_idx_t        first;
  slot_idx_t        rem_idx;
  slot_idx_t        free_slot;

  // fibonacci lfsr with taps 16, 14, 13, 11, free running
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= RNG_SEED;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    end
  end

  assign rnd = lfsr_q[SLOT_W-1:0];  // depth is a power of two so no wrap is needed

  always_comb begin
    for (int k = 0; k < DEPTH; k++) begin
      cand[k] = ready_i[DIST[k][rnd]];
    end
    first = '0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      if (cand[k]) begin
        first = SLOT_W'(k);
      end
    end
    rem_idx = DIST[first][rnd];
  end

  always_comb begin
    free_slot = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ev.valid[i]) begin
        free_slot = SLOT_W'(i);
      end
    end
  end

  assign pick_ok_o  = |ready_i;
  assign ev.rem_idx = rem_idx;
  // a full buffer can only accept into the slot that leaves in the same cycle
  assign ev.ins_idx = ev.rem_en ? rem_idx : free_slot;

endmodule

// ==== shuffle_buffer.sv ====
`timescale 1ns/100ps

module shuffle_buffer import shuffle_pkg::*; #(
  parameter int unsigned  DEPTH         = 4,
  parameter int unsigned  NUM_PHYS_REGS = 64,
  parameter logic [15:0]  RNG_SEED      = 16'hACE1,
  localparam int unsigned PHYS_W        = $clog2(NUM_PHYS_REGS)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              in_valid_i,  // upstream (prefetch) side
  output logic              in_ready_o,
  input  instr_t            in_instr_i,
  input  addr_t             in_addr_i,
  input  logic              branch_i,    // ID/EX requests a new pc
  output logic              valid_o,     // downstream (ID/EX) side
  input  logic              ready_i,
  output instr_t            rdata_o,
  output addr_t             addr_o,
  output logic [PHYS_W-1:0] rd_o,
  output logic [PHYS_W-1:0] rs1_o,
  output logic [PHYS_W-1:0] rs2_o
);

  typedef logic [PHYS_W-1:0] phys_idx_t;

  shuffle_if #(.DEPTH(DEPTH)) ev ();

  instr_class_t     cls;
  log_reg_t         rd_log;
  log_reg_t         rs1_log;
  log_reg_t         rs2_log;
  phys_idx_t        prd;
  phys_idx_t        prs1;
  phys_idx_t        prs2;
  logic [DEPTH-1:0] slot_ready;
  logic             pick_ok;

  logic [DEPTH-1:0] valid_q;
  addr_t            addr_q [DEPTH];
  instr_t           data_q [DEPTH];
  phys_idx_t        rd_q [DEPTH];
  phys_idx_t        rs1_q [DEPTH];
  phys_idx_t        rs2_q [DEPTH];

  logic             fence_q;         // acceptance halted behind a pc-changing instruction
  addr_t            fence_pc_q;      // pc of that instruction
  logic             fence_issued_q;  // it went to ID/EX on the previous edge
  logic             full;
  logic             not_empty;
  logic             not_taken;

  assign full      = &valid_q;
  assign not_empty = |valid_q;
  // ID/EX drops ready_i right after an instruction that redirects the pc
  assign not_taken = fence_issued_q && ready_i;

  // below full the buffer only drains while fenced, otherwise it keeps filling to shuffle
  assign valid_o    = !branch_i && (full || (not_empty && fence_q)) && pick_ok;
  assign in_ready_o = !branch_i && (!full || ev.rem_en) && (!fence_q || not_taken);

  assign ev.rem_en = ready_i && valid_o;
  assign ev.ins_en = in_valid_i && in_ready_o;
  assign ev.valid  = valid_q;

  instr_classify u_classify (
    .in_instr_i (in_instr_i),
    .cls_o      (cls),
    .rd_o       (rd_log),
    .rs1_o      (rs1_log),
    .rs2_o      (rs2_log)
  );

  rename_table #(.DEPTH(DEPTH), .NUM_PHYS_REGS(NUM_PHYS_REGS)) u_rename (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .ev     (ev),
    .cls_i  (cls),
    .rd_i   (rd_log),
    .rs1_i  (rs1_log),
    .rs2_i  (rs2_log),
    .prd_o  (prd),
    .prs1_o (prs1),
    .prs2_o (prs2)
  );

  dep_matrix #(.DEPTH(DEPTH), .NUM_PHYS_REGS(NUM_PHYS_REGS)) u_deps (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ev      (ev),
    .cls_i   (cls),
    .prd_i   (prd),
    .prs1_i  (prs1),
    .prs2_i  (prs2),
    .ready_o (slot_ready)
  );

  issue_select #(.DEPTH(DEPTH), .RNG_SEED(RNG_SEED)) u_select (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ev        (ev),
    .ready_i   (slot_ready),
    .pick_ok_o (pick_ok)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q        <= '0;
      fence_q        <= 1'b0;
      fence_issued_q <= 1'b0;
    end else begin
      if (ev.rem_en) begin
        valid_q[ev.rem_idx] <= 1'b0;
      end
      if (ev.ins_en) begin
        valid_q[ev.ins_idx] <= 1'b1;  // same slot on a combined cycle, set wins
      end
      fence_issued_q <= fence_q && ev.rem_en && (addr_o == fence_pc_q);
      if (branch_i || not_taken) begin
        fence_q <= 1'b0;
      end
      // a fence accepted in the clearing cycle keeps the buffer fenced
      if (ev.ins_en && cls.is_fence) begin
        fence_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ev.ins_en) begin
      addr_q[ev.ins_idx] <= in_addr_i;
      data_q[ev.ins_idx] <= in_instr_i;
      rd_q[ev.ins_idx]   <= prd;
      rs1_q[ev.ins_idx]  <= prs1;
      rs2_q[ev.ins_idx]  <= prs2;
    end
    if (ev.ins_en && cls.is_fence) begin
      fence_pc_q <= in_addr_i;
    end
  end

  assign rdata_o = data_q[ev.rem_idx];
  assign addr_o  = addr_q[ev.rem_idx];
  assign rd_o    = rd_q[ev.rem_idx];
  assign rs1_o   = rs1_q[ev.rem_idx];
  assign rs2_o   = rs2_q[ev.rem_idx];

endmodule

// ==== shuffle_buffer_assertions.sv ====
`timescale 1ns/100ps

module shuffle_buffer_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic branch_i,
  input logic valid_o,
  input logic in_ready_o
);

  // a pc redirect blocks both sides of the buffer
  no_issue_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_i |-> !valid_o)
    else $error("valid_o high while branch_i is high");

  no_accept_on_branch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_i |-> !in_ready_o)
    else $error("in_ready_o high while branch_i is high");

  // the buffer starts empty, so nothing can be offered right after reset
  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_o)
    else $error("valid_o high in the first cycle after reset");

endmodule

bind shuffle_buffer shuffle_buffer_assertions u_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .branch_i   (branch_i),
  .valid_o    (valid_o),
  .in_ready_o (in_ready_o)
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned PERIOD     = 40,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;  // released with the same skew as the other inputs
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== tb_shuffle_buffer.sv ====
`timescale 1ns/100ps

module tb_shuffle_buffer import shuffle_pkg::*;;

  localparam int unsigned DEPTH = 4;
  localparam int          N     = 19;       // entries in the instruction table
  localparam int          LIMIT = N * 20;   // cycles before the run is abandoned
  localparam addr_t       BASE  = 32'h100;  // pc of the first table entry

  typedef struct {
    instr_t w;
    bit     urd, urs1, urs2;  // expected register use
    bit     mem, env, fnc;    // expected ordering classes
    bit     taken;            // ID/EX redirects after this fence-class entry
  } entry_t;

  logic clk, rst_n;
  logic in_valid_i, in_ready_o, branch_i, valid_o, ready_i;
  instr_t in_instr_i, rdata_o;
  addr_t in_addr_i, addr_o;
  logic [5:0] rd_o, rs1_o, rs2_o;

  entry_t tbl [$];
  bit accepted [N];
  bit issued [N];
  logic [5:0] rd_phys [N];  // physical rd seen when each entry issued
  int acc_cyc [N];          // cycle in which each entry was handed over
  int iss_cyc [N];          // cycle in which each entry went to ID/EX
  int errors, issued_cnt, outstanding, idx, cyc, after_fence;
  int seed = 64125;
  bit fence_pend, timed_out, acc, iss;

  tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  shuffle_buffer #(.DEPTH(DEPTH), .NUM_PHYS_REGS(64)) shuffle_buffer_i (
    .clk_i(clk), .rst_ni(rst_n), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .in_instr_i(in_instr_i), .in_addr_i(in_addr_i), .branch_i(branch_i),
    .valid_o(valid_o), .ready_i(ready_i), .rdata_o(rdata_o), .addr_o(addr_o),
    .rd_o(rd_o), .rs1_o(rs1_o), .rs2_o(rs2_o)
  );

  function automatic instr_t enc(logic [6:0] f7, log_reg_t rs2, log_reg_t rs1,
                                 logic [2:0] f3, log_reg_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  task automatic add(instr_t w, bit urd, bit urs1, bit urs2, bit mem, bit env,
                     bit fnc, bit taken);
    entry_t e;
    e = '{w, urd, urs1, urs2, mem, env, fnc, taken};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    add(enc(0, 5, 0, 0, 1, 7'h13), 1, 1, 0, 0, 0, 0, 0);            // addi x1,x0,5
    add(enc(0, 1, 1, 0, 2, OPC_OP), 1, 1, 1, 0, 0, 0, 0);           // add x2,x1,x1
    add(enc(0, 0, 2, 2, 3, OPC_LOAD), 1, 1, 0, 1, 0, 0, 0);         // lw x3,0(x2)
    add(enc(0, 3, 1, 2, 4, OPC_STORE), 0, 1, 1, 1, 0, 0, 0);        // sw x3,4(x1)
    add(enc(7'h12, 3, 0, 0, 4, OPC_LUI), 1, 0, 0, 0, 0, 0, 0);      // lui x4
    add(enc(0, 3, 4, 0, 5, OPC_OP), 1, 1, 1, 0, 0, 0, 0);           // add x5,x4,x3
    add(enc(7'h18, 0, 5, 2, 6, OPC_SYSTEM), 1, 1, 0, 0, 1, 0, 0);   // csrrs x6,mstatus,x5
    add(enc(7'h20, 6, 5, 0, 1, OPC_OP), 1, 1, 1, 0, 0, 0, 0);       // sub x1,x5,x6
    add(enc(0, 2, 1, 0, 8, OPC_BRANCH), 0, 1, 1, 0, 0, 1, 0);       // beq x1,x2 not taken
    add(enc(0, 8, 1, 2, 7, OPC_LOAD), 1, 1, 0, 1, 0, 0, 0);         // lw x7,8(x1)
    add(enc(0, 7, 2, 2, 12, OPC_STORE), 0, 1, 1, 1, 0, 0, 0);       // sw x7,12(x2)
    add(enc(0, 1, 7, 0, 2, OPC_OP), 1, 1, 1, 0, 0, 0, 0);           // add x2,x7,x1
    add(enc(0, 1, 0, 0, 8, OPC_AUIPC), 1, 0, 0, 0, 0, 0, 0);        // auipc x8
    add(enc(0, 8, 0, 0, 9, OPC_JAL), 1, 0, 0, 0, 0, 1, 1);          // jal x9 taken
    add(enc(0, 1, 9, 0, 10, 7'h13), 1, 1, 0, 0, 0, 0, 0);           // addi x10,x9,1
    add(enc(0, 8, 10, 0, 11, OPC_OP), 1, 1, 1, 0, 0, 0, 0);         // add x11,x10,x8
    add(enc(0, 2, 11, 4, 3, OPC_OP), 1, 1, 1, 0, 0, 0, 0);          // xor x3,x11,x2
    add(enc(0, 3, 3, 7, 4, OPC_OP), 1, 1, 1, 0, 0, 0, 0);           // and x4,x3,x3
    add(32'h0000_0073, 0, 0, 0, 0, 1, 1, 1);                        // ecall drains the tail
  endtask

  // latest earlier entry writing logical register r, -1 for x0 or none
  function automatic int latest_writer(int s, log_reg_t r);
    for (int j = s - 1; j >= 0; j--) begin
      if (r != 0 && tbl[j].urd && tbl[j].w[11:7] == r) return j;
    end
    return -1;
  endfunction

  function automatic logic [5:0] src_expect(int s, bit used, log_reg_t r);
    int j;
    j = latest_writer(s, r);
    if (!used) return '0;
    if (j < 0) return 6'(r);  // reset mapping is the identity
    return rd_phys[j];
  endfunction

  function automatic bit must_wait(int j, int s);
    bit raw;
    raw = (tbl[s].urs1 && latest_writer(s, tbl[s].w[19:15]) == j)
          || (tbl[s].urs2 && latest_writer(s, tbl[s].w[24:20]) == j);
    return raw || (tbl[j].mem && tbl[s].mem) || tbl[j].env || tbl[s].env;
  endfunction

  task automatic check_issue();
    int s;
    logic [5:0] e1, e2;
    s = int'((addr_o - BASE) >> 2);
    if (addr_o < BASE || s >= N || addr_o[1:0] != 0 || !accepted[s] || issued[s]) begin
      $display("failure at %0t: pc %h issued but not outstanding", $time, addr_o);
      errors++;
      return;
    end
    if (rdata_o !== tbl[s].w) begin
      $display("ERROR %0t: rdata_o expected %h got %h", $time, tbl[s].w, rdata_o);
      errors++;
    end
    for (int j = 0; j < s; j++) begin
      if (!issued[j] && must_wait(j, s)) begin
        $display("failure at %0t: entry %0d issued before older entry %0d", $time, s, j);
        errors++;
      end
    end
    e1 = src_expect(s, tbl[s].urs1, tbl[s].w[19:15]);
    e2 = src_expect(s, tbl[s].urs2, tbl[s].w[24:20]);
    if (rs1_o !== e1) begin
      $display("ERROR %0t: rs1_o expected %0d got %0d", $time, e1, rs1_o);
      errors++;
    end
    if (rs2_o !== e2) begin
      $display("ERROR %0t: rs2_o expected %0d got %0d", $time, e2, rs2_o);
      errors++;
    end
    if (tbl[s].urd && tbl[s].w[11:7] != 0) begin
      // a fresh register is never p0 and never one still mapped for a source
      if (rd_o == 0 || (tbl[s].urs1 && rd_o == rs1_o) || (tbl[s].urs2 && rd_o == rs2_o)) begin
        $display("failure at %0t: entry %0d got bad new rd p%0d", $time, s, rd_o);
        errors++;
      end
    end else if (rd_o !== 0) begin
      $display("ERROR %0t: rd_o expected 0 got %0d", $time, rd_o);
      errors++;
    end
    // two entries that sat in the buffer together never share a destination
    for (int j = 0; j < N; j++) begin
      if (issued[j] && iss_cyc[j] >= acc_cyc[s] && rd_o != 0 && rd_phys[j] == rd_o) begin
        $display("failure at %0t: entry %0d got p%0d still held by entry %0d",
                 $time, s, rd_o, j);
        errors++;
      end
    end
    issued[s] = 1;
    rd_phys[s] = rd_o;
    iss_cyc[s] = cyc;
    outstanding--;
    issued_cnt++;
    if (tbl[s].fnc) begin
      fence_pend = 0;
      after_fence = tbl[s].taken ? 2 : 1;  // redirect pulse or ready held high
    end
  endtask

  initial begin
    build_table();
    in_valid_i = 0;
    in_instr_i = '0;
    in_addr_i = '0;
    branch_i = 0;
    ready_i = 0;
    @(posedge rst_n);
    @(negedge clk);
    if (valid_o !== 1'b0) begin
      $display("ERROR %0t: valid_o expected 0 got %b", $time, valid_o);
      errors++;
    end
    while (issued_cnt < N && !timed_out) begin
      @(posedge clk);
      #2;
      branch_i = (after_fence == 2);
      if (after_fence == 2) ready_i = 0;
      else if (after_fence == 1) ready_i = 1;  // ID/EX keeps going, branch not taken
      else if (cyc < 12) ready_i = 0;  // buffer fills, then sits full and stalled
      else ready_i = ($random(seed) & 3) != 0;
      after_fence = 0;
      in_valid_i = (idx < N);
      if (idx < N) begin
        in_instr_i = tbl[idx].w;
        in_addr_i = BASE + addr_t'(idx * 4);
      end
      @(negedge clk);  // all inputs settled, the next edge sees these values
      acc = in_valid_i && in_ready_o;
      iss = valid_o && ready_i;
      if (branch_i && (valid_o || in_ready_o)) begin
        $display("failure at %0t: handshake open while branch_i is high", $time);
        errors++;
      end
      if (outstanding == DEPTH && !ready_i && in_ready_o) begin
        $display("failure at %0t: in_ready_o high with a full stalled buffer", $time);
        errors++;
      end
      if (acc && fence_pend) begin
        $display("failure at %0t: entry %0d accepted behind an unissued fence", $time, idx);
        errors++;
      end
      if (iss) check_issue();
      if (acc) begin
        accepted[idx] = 1;
        acc_cyc[idx] = cyc;
        outstanding++;
        if (tbl[idx].fnc) fence_pend = 1;
        idx++;
      end
      cyc++;
      if (cyc >= LIMIT) timed_out = 1;
    end
    if (timed_out) begin
      $display("timeout: only %0d of %0d entries issued in %0d cycles", issued_cnt, N, LIMIT);
      errors++;
    end
    for (int i = 0; i < N; i++) begin
      if (!issued[i]) begin
        $display("entry %0d never reached ID/EX", i);
        errors++;
      end
    end
    $display("errors: %0d, issued: %0d of %0d", errors, issued_cnt, N);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== shuffle_buffer.f ====
shuffle_pkg.sv
shuffle_if.sv
instr_classify.sv
rename_table.sv
dep_matrix.sv
issue_select.sv
shuffle_buffer.sv
shuffle_buffer_assertions.sv
tb_clock_gen.sv
tb_shuffle_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_shuffle_buffer
FILELIST  ?= shuffle_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) $(VFLAGS)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
